/* Makefile */
TOP := tb_ekf_step

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "sim failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* design/ekf_pkg.sv */
`default_nettype none

package ekf_pkg;

  // state and result word width
  localparam int DATA_W      = 32;
  // landmark table
  localparam int LM_NUM      = 8;
  localparam int LM_IDX_W    = 3;
  // nonlinear unit result count
  localparam int NL_RESULTS  = 6;
  // term words carried per record
  localparam int REC_TERMS   = 10;
  // record fifo and consumer credits
  localparam int QUEUE_DEPTH = 4;
  localparam int REC_CREDITS = 4;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int FREE_W      = $clog2(QUEUE_DEPTH + 1);
  localparam int CREDIT_W    = $clog2(REC_CREDITS + 1);

  typedef enum logic [1:0] {
    STEP_PREDICT = 2'd0,
    STEP_NEWLM   = 2'd1,
    STEP_UPDATE  = 2'd2
  } step_kind_t;

  // one signed datapath word
  typedef logic signed [DATA_W-1:0] word_t;

  // robot pose
  typedef struct packed {
    word_t x;
    word_t y;
    word_t theta;
  } pose_t;

  // landmark coordinates
  typedef struct packed {
    word_t lx;
    word_t ly;
  } lm_pos_t;

  typedef struct packed {
    step_kind_t          kind;
    logic [LM_IDX_W-1:0] lm_idx;
  } step_req_t;

  // operands held toward the nonlinear unit
  typedef struct packed {
    pose_t               pose;
    lm_pos_t             lm;
    step_kind_t          kind;
    logic [LM_IDX_W-1:0] lm_idx;
  } nl_op_t;

  // r0 sits at index 0
  typedef word_t [NL_RESULTS-1:0] nl_res_t;

  // terms[0] is the first term of the step, unused terms zero
  typedef struct packed {
    step_kind_t             kind;
    logic [LM_IDX_W-1:0]    lm_idx;
    word_t [REC_TERMS-1:0]  terms;
  } step_rec_t;

endpackage

`default_nettype wire

/* design/ekf_step_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ekf_step_top (
  input  wire logic                 clk,
  input  wire logic                 sys_rst,
  // step requests from the processor side
  input  wire logic                 i_req_val,
  input  wire ekf_pkg::step_req_t   i_req,
  output logic                      o_req_rdy,
  // nonlinear unit
  output logic                      o_nl_init,
  output ekf_pkg::nl_op_t           o_nl_op,
  input  wire logic                 i_nl_done,
  input  wire ekf_pkg::nl_res_t     i_nl_res,
  // record stream, credit based
  output logic                      o_rec_val,
  output ekf_pkg::step_rec_t        o_rec,
  input  wire logic                 i_credit
);

  // store read path
  ekf_pkg::pose_t                   pose;
  ekf_pkg::lm_pos_t                 lm_pos;
  logic [ekf_pkg::LM_IDX_W-1:0]     lm_rd_idx;
  // store write path
  logic                             pose_we;
  ekf_pkg::pose_t                   pose_wr;
  logic                             lm_we;
  logic [ekf_pkg::LM_IDX_W-1:0]     lm_wr_idx;
  ekf_pkg::lm_pos_t                 lm_wr;
  // issue to unpack to queue
  ekf_pkg::step_req_t               step;
  logic                             push;
  ekf_pkg::step_rec_t               rec;
  logic [ekf_pkg::FREE_W-1:0]       queue_free;

  pose_map_store u_store (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_lm_rd_idx (lm_rd_idx),
    .o_pose      (pose),
    .o_lm_pos    (lm_pos),
    .i_pose_we   (pose_we),
    .i_pose_wr   (pose_wr),
    .i_lm_we     (lm_we),
    .i_lm_wr_idx (lm_wr_idx),
    .i_lm_wr     (lm_wr)
  );

  step_issue u_issue (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .i_req_val    (i_req_val),
    .i_req        (i_req),
    .o_req_rdy    (o_req_rdy),
    .i_pose       (pose),
    .i_lm_pos     (lm_pos),
    .o_lm_rd_idx  (lm_rd_idx),
    .o_nl_init    (o_nl_init),
    .o_nl_op      (o_nl_op),
    .i_nl_done    (i_nl_done),
    .i_queue_free (queue_free),
    .o_step       (step)
  );

  result_unpack u_unpack (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_nl_done   (i_nl_done),
    .i_nl_res    (i_nl_res),
    .i_step      (step),
    .i_pose      (pose),
    .i_lm_pos    (lm_pos),
    .o_pose_we   (pose_we),
    .o_pose_wr   (pose_wr),
    .o_lm_we     (lm_we),
    .o_lm_wr_idx (lm_wr_idx),
    .o_lm_wr     (lm_wr),
    .o_push      (push),
    .o_rec       (rec)
  );

  record_queue u_queue (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_push    (push),
    .i_rec     (rec),
    .i_credit  (i_credit),
    .o_rec_val (o_rec_val),
    .o_rec     (o_rec),
    .o_free    (queue_free)
  );

endmodule

`default_nettype wire

/* design/pose_map_store.sv */
`timescale 1ns/1ps
`default_nettype none

module pose_map_store (
  input  wire logic                         clk,
  input  wire logic                         sys_rst,
  // combinational read side
  input  wire logic [ekf_pkg::LM_IDX_W-1:0] i_lm_rd_idx,
  output ekf_pkg::pose_t                    o_pose,
  output ekf_pkg::lm_pos_t                  o_lm_pos,
  // pose write
  input  wire logic                         i_pose_we,
  input  wire ekf_pkg::pose_t               i_pose_wr,
  // landmark write
  input  wire logic                         i_lm_we,
  input  wire logic [ekf_pkg::LM_IDX_W-1:0] i_lm_wr_idx,
  input  wire ekf_pkg::lm_pos_t             i_lm_wr
);

  ekf_pkg::pose_t   pose_q;
  ekf_pkg::lm_pos_t lm_q [ekf_pkg::LM_NUM];

  // robot pose register
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      pose_q <= '0;
    end else if (i_pose_we) begin
      pose_q <= i_pose_wr;
    end
  end

  // landmark table starts with every slot at the origin
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int i = 0; i < ekf_pkg::LM_NUM; i++) begin
        lm_q[i] <= '0;
      end
    end else if (i_lm_we) begin
      lm_q[i_lm_wr_idx] <= i_lm_wr;
    end
  end

  // reads see the state written on the previous edge
  assign o_pose   = pose_q;
  assign o_lm_pos = lm_q[i_lm_rd_idx];

  // a step never writes the pose and a landmark together
  a_one_write : assert property (
    @(posedge clk) disable iff (sys_rst)
    !(i_pose_we && i_lm_we)
  );

endmodule

`default_nettype wire

/* design/record_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module record_queue (
  input  wire logic                         clk,
  input  wire logic                         sys_rst,
  // push side
  input  wire logic                         i_push,
  input  wire ekf_pkg::step_rec_t           i_rec,
  // credit return from the consumer
  input  wire logic                         i_credit,
  // record output
  output logic                              o_rec_val,
  output ekf_pkg::step_rec_t                o_rec,
  // free slot count toward issue
  output logic [ekf_pkg::FREE_W-1:0]        o_free
);

  ekf_pkg::step_rec_t                 mem [ekf_pkg::QUEUE_DEPTH];
  logic [ekf_pkg::QPTR_W-1:0]         wr_ptr_q;
  logic [ekf_pkg::QPTR_W-1:0]         rd_ptr_q;
  logic [ekf_pkg::FREE_W-1:0]         count_q;
  logic [ekf_pkg::CREDIT_W-1:0]       credit_q;
  logic                               pop;

  // head goes out whenever there is data and credit
  assign pop       = (count_q != '0) && (credit_q != '0);
  assign o_rec_val = pop;
  assign o_rec     = mem[rd_ptr_q];
  assign o_free    = ekf_pkg::FREE_W'(ekf_pkg::QUEUE_DEPTH) - count_q;

  // record storage
  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr_q] <= i_rec;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr_q <= (wr_ptr_q == ekf_pkg::QPTR_W'(ekf_pkg::QUEUE_DEPTH - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ekf_pkg::QPTR_W'(ekf_pkg::QUEUE_DEPTH - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + ekf_pkg::FREE_W'(i_push) - ekf_pkg::FREE_W'(pop);
    end
  end

  // one credit spent per record sent
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      credit_q <= ekf_pkg::CREDIT_W'(ekf_pkg::REC_CREDITS);
    end else begin
      credit_q <= credit_q + ekf_pkg::CREDIT_W'(i_credit) - ekf_pkg::CREDIT_W'(pop);
    end
  end

  // issue holds off requests when no slot is free
  a_no_push_full : assert property (
    @(posedge clk) disable iff (sys_rst)
    i_push |-> (count_q != ekf_pkg::FREE_W'(ekf_pkg::QUEUE_DEPTH))
  );

  // consumer never returns more than it was granted
  a_credit_max : assert property (
    @(posedge clk) disable iff (sys_rst)
    int'(credit_q) <= ekf_pkg::REC_CREDITS
  );

endmodule

`default_nettype wire

/* design/result_unpack.sv */
`timescale 1ns/1ps
`default_nettype none

module result_unpack (
  input  wire logic                         clk,
  input  wire logic                         sys_rst,
  // nonlinear results
  input  wire logic                         i_nl_done,
  input  wire ekf_pkg::nl_res_t             i_nl_res,
  // step in flight and its current state
  input  wire ekf_pkg::step_req_t           i_step,
  input  wire ekf_pkg::pose_t               i_pose,
  input  wire ekf_pkg::lm_pos_t             i_lm_pos,
  // state writes
  output logic                              o_pose_we,
  output ekf_pkg::pose_t                    o_pose_wr,
  output logic                              o_lm_we,
  output logic [ekf_pkg::LM_IDX_W-1:0]      o_lm_wr_idx,
  output ekf_pkg::lm_pos_t                  o_lm_wr,
  // record toward the queue
  output logic                              o_push,
  output ekf_pkg::step_rec_t                o_rec
);

  ekf_pkg::pose_t     pose_nxt;
  ekf_pkg::lm_pos_t   lm_nxt;
  ekf_pkg::step_rec_t rec_nxt;

  // state updates, only one of them is written per step
  always_comb begin
    pose_nxt.x     = i_pose.x + i_nl_res[2];
    pose_nxt.y     = i_pose.y + i_nl_res[3];
    pose_nxt.theta = i_pose.theta + i_nl_res[1];
    lm_nxt.lx      = i_lm_pos.lx + i_nl_res[3];
    lm_nxt.ly      = i_lm_pos.ly + i_nl_res[2];
  end

  // term map per step kind, terms in record order
  always_comb begin
    rec_nxt.kind   = i_step.kind;
    rec_nxt.lm_idx = i_step.lm_idx;
    rec_nxt.terms  = '0;
    case (i_step.kind)
      ekf_pkg::STEP_PREDICT: begin
        // Fxi13, Fxi23
        rec_nxt.terms[0] = -i_nl_res[3];
        rec_nxt.terms[1] = i_nl_res[2];
      end
      ekf_pkg::STEP_NEWLM: begin
        // Gxi13, Gxi23
        rec_nxt.terms[0] = -i_nl_res[2];
        rec_nxt.terms[1] = i_nl_res[3];
        // Gz 2x2, row major
        rec_nxt.terms[2] = i_nl_res[0];
        rec_nxt.terms[3] = -i_nl_res[2];
        rec_nxt.terms[4] = i_nl_res[1];
        rec_nxt.terms[5] = i_nl_res[3];
      end
      ekf_pkg::STEP_UPDATE: begin
        // Hxi 2x2
        rec_nxt.terms[0] = -i_nl_res[4];
        rec_nxt.terms[1] = -i_nl_res[5];
        rec_nxt.terms[2] = i_nl_res[2];
        rec_nxt.terms[3] = -i_nl_res[3];
        // Hz 2x2, mirror of Hxi
        rec_nxt.terms[4] = i_nl_res[4];
        rec_nxt.terms[5] = i_nl_res[5];
        rec_nxt.terms[6] = -i_nl_res[2];
        rec_nxt.terms[7] = i_nl_res[3];
        // innovation
        rec_nxt.terms[8] = i_nl_res[0];
        rec_nxt.terms[9] = i_nl_res[1];
      end
      default: begin
        rec_nxt.terms = '0;
      end
    endcase
  end

  // strobes one cycle after done
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_pose_we <= 1'b0;
      o_lm_we   <= 1'b0;
      o_push    <= 1'b0;
    end else begin
      o_pose_we <= i_nl_done && (i_step.kind == ekf_pkg::STEP_PREDICT);
      o_lm_we   <= i_nl_done && (i_step.kind == ekf_pkg::STEP_NEWLM);
      // every step yields a record
      o_push    <= i_nl_done;
    end
  end

  // payload follows the strobes
  always_ff @(posedge clk) begin
    if (i_nl_done) begin
      o_pose_wr   <= pose_nxt;
      o_lm_wr     <= lm_nxt;
      o_lm_wr_idx <= i_step.lm_idx;
      o_rec       <= rec_nxt;
    end
  end

endmodule

`default_nettype wire

/* design/step_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module step_issue (
  input  wire logic                         clk,
  input  wire logic                         sys_rst,
  // request handshake
  input  wire logic                         i_req_val,
  input  wire ekf_pkg::step_req_t           i_req,
  output logic                              o_req_rdy,
  // state read
  input  wire ekf_pkg::pose_t               i_pose,
  input  wire ekf_pkg::lm_pos_t             i_lm_pos,
  output logic [ekf_pkg::LM_IDX_W-1:0]      o_lm_rd_idx,
  // nonlinear unit
  output logic                              o_nl_init,
  output ekf_pkg::nl_op_t                   o_nl_op,
  input  wire logic                         i_nl_done,
  // free record slots
  input  wire logic [ekf_pkg::FREE_W-1:0]   i_queue_free,
  // step in flight, toward unpack
  output ekf_pkg::step_req_t                o_step
);

  logic               busy_q;
  logic               done_q;
  logic               accept;
  ekf_pkg::step_req_t step_q;

  // only one step at a time, and only with room for its record
  assign o_req_rdy = !busy_q && (i_queue_free != '0);
  assign accept    = i_req_val && o_req_rdy;

  // while busy keep reading the running step's slot
  // so unpack sees the landmark that was sent out
  assign o_lm_rd_idx = busy_q ? step_q.lm_idx : i_req.lm_idx;
  assign o_step      = step_q;

  // busy spans accept up to the cycle after done
  // by then the state write and the push have landed
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      o_nl_init <= 1'b0;
    end else begin
      o_nl_init <= accept;
      done_q    <= i_nl_done;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  // operands captured at accept, stable until done
  always_ff @(posedge clk) begin
    if (accept) begin
      step_q         <= i_req;
      o_nl_op.pose   <= i_pose;
      o_nl_op.lm     <= i_lm_pos;
      o_nl_op.kind   <= i_req.kind;
      o_nl_op.lm_idx <= i_req.lm_idx;
    end
  end

  // the unit may only answer a step that was issued
  a_done_when_busy : assert property (
    @(posedge clk) disable iff (sys_rst)
    i_nl_done |-> busy_q
  );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 8
) (
  output logic o_clk,
  output logic o_rst
);

  // free running clock
  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // reset held for a fixed number of rising edges, released on an edge
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* dv/tb_ekf_step.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ekf_step;

  localparam int     WAIT_LIMIT = 400;
  localparam integer SEED       = 32'hf1b3;

  logic                 clk;
  logic                 sys_rst;
  logic                 i_req_val = 1'b0;
  ekf_pkg::step_req_t   i_req     = '0;
  logic                 o_req_rdy;
  logic                 o_nl_init;
  ekf_pkg::nl_op_t      o_nl_op;
  logic                 i_nl_done = 1'b0;
  ekf_pkg::nl_res_t     i_nl_res  = '0;
  logic                 o_rec_val;
  ekf_pkg::step_rec_t   o_rec;
  logic                 i_credit  = 1'b0;

  // reference copy of the pose and landmark table
  ekf_pkg::pose_t       ref_pose;
  ekf_pkg::lm_pos_t     ref_lm [ekf_pkg::LM_NUM];
  // steps sent but not yet seen at init
  ekf_pkg::step_req_t   req_q [$];
  // records expected in order
  ekf_pkg::step_rec_t   exp_q [$];
  ekf_pkg::step_req_t   cur_req;

  integer nl_seed = SEED;
  integer cr_seed = SEED;
  integer st_seed = SEED;
  int     nl_wait;
  int     owed;
  int     err_count  = 0;
  int     sent_count = 0;
  int     rec_count  = 0;
  int     init_count = 0;
  logic   hold_credits  = 1'b0;
  logic   no_rec_window = 1'b0;

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(8)) u_clk_gen (
    .o_clk (clk),
    .o_rst (sys_rst)
  );

  ekf_step_top DUT (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_req_val (i_req_val),
    .i_req     (i_req),
    .o_req_rdy (o_req_rdy),
    .o_nl_init (o_nl_init),
    .o_nl_op   (o_nl_op),
    .i_nl_done (i_nl_done),
    .i_nl_res  (i_nl_res),
    .o_rec_val (o_rec_val),
    .o_rec     (o_rec),
    .i_credit  (i_credit)
  );

  // operands the next step should carry per the reference state
  function automatic ekf_pkg::nl_op_t expect_op(input ekf_pkg::step_req_t req);
    ekf_pkg::nl_op_t op;
    op.pose   = ref_pose;
    op.lm     = ref_lm[req.lm_idx];
    op.kind   = req.kind;
    op.lm_idx = req.lm_idx;
    return op;
  endfunction

  // expected record of one step
  // advances the reference state too
  function automatic ekf_pkg::step_rec_t ref_step(input ekf_pkg::step_req_t req,
                                                  input ekf_pkg::nl_res_t r);
    ekf_pkg::step_rec_t rec;
    ekf_pkg::word_t     t [ekf_pkg::REC_TERMS];
    for (int i = 0; i < ekf_pkg::REC_TERMS; i++) begin
      t[i] = '0;
    end
    case (req.kind)
      ekf_pkg::STEP_PREDICT: begin
        // robot moves by (r2, r3) and turns by r1
        ref_pose.x     = ref_pose.x + r[2];
        ref_pose.y     = ref_pose.y + r[3];
        ref_pose.theta = ref_pose.theta + r[1];
        t[0] = -r[3];
        t[1] = r[2];
      end
      ekf_pkg::STEP_NEWLM: begin
        // note the swapped offsets on the landmark
        ref_lm[req.lm_idx].lx = ref_lm[req.lm_idx].lx + r[3];
        ref_lm[req.lm_idx].ly = ref_lm[req.lm_idx].ly + r[2];
        t[0] = -r[2];
        t[1] = r[3];
        t[2] = r[0];
        t[3] = -r[2];
        t[4] = r[1];
        t[5] = r[3];
      end
      ekf_pkg::STEP_UPDATE: begin
        // Hxi then Hz then innovation
        t[0] = -r[4];
        t[1] = -r[5];
        t[2] = r[2];
        t[3] = -r[3];
        t[4] = r[4];
        t[5] = r[5];
        t[6] = -r[2];
        t[7] = r[3];
        t[8] = r[0];
        t[9] = r[1];
      end
      default: begin
        t[0] = '0;
      end
    endcase
    rec.kind   = req.kind;
    rec.lm_idx = req.lm_idx;
    for (int i = 0; i < ekf_pkg::REC_TERMS; i++) begin
      rec.terms[i] = t[i];
    end
    return rec;
  endfunction

  task automatic compare_rec(input ekf_pkg::step_rec_t got, input ekf_pkg::step_rec_t exp);
    if (got !== exp) begin
      err_count++;
      $display("Error at %0d ns: o_rec got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic compare_op(input ekf_pkg::nl_op_t got, input ekf_pkg::nl_op_t exp);
    if (got !== exp) begin
      err_count++;
      $display("Error at %0d ns: o_nl_op got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_count++;
      $display("Error at %0d ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("summary: %0d steps, %0d inits, %0d records, %0d errors",
             sent_count, init_count, rec_count, err_count);
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic abort_run(input string what);
    err_count++;
    $display("Timeout at %0d ns: %s", $time, what);
    finish_run();
  endtask

  task automatic report_test(input string name, input int err_at_start);
    if (err_count == err_at_start) begin
      $display("test %s ok", name);
    end else begin
      $display("test %s FAILED with %0d errors", name, err_count - err_at_start);
    end
  endtask

  function automatic ekf_pkg::step_kind_t random_kind();
    return ekf_pkg::step_kind_t'({$random(st_seed)} % 3);
  endfunction

  function automatic logic [ekf_pkg::LM_IDX_W-1:0] random_idx();
    return ekf_pkg::LM_IDX_W'($random(st_seed));
  endfunction

  // one request through the valid/ready handshake
  task automatic send_req(input ekf_pkg::step_kind_t kind,
                          input logic [ekf_pkg::LM_IDX_W-1:0] idx);
    ekf_pkg::step_req_t req;
    int                 waited;
    req.kind   = kind;
    req.lm_idx = idx;
    waited     = 0;
    @(posedge clk);
    i_req_val <= 1'b1;
    i_req     <= req;
    do begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) abort_run("request was never accepted");
    end while (!o_req_rdy);
    // transfer happened on this edge
    req_q.push_back(req);
    sent_count++;
    i_req_val <= 1'b0;
    i_req     <= '0;
    // init is due exactly one cycle after the transfer
    @(posedge clk);
    compare_flag("o_nl_init", o_nl_init, 1'b1);
    @(posedge clk);
    compare_flag("o_nl_init", o_nl_init, 1'b0);
  endtask

  // every sent step has come back as a record
  task automatic wait_drained(input string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (rec_count < sent_count) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) abort_run(what);
    end
  endtask

  task automatic wait_queued(input int n);
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_q.size() < n) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) abort_run("steps did not complete with credits withheld");
    end
  endtask

  // nonlinear unit model with random latency and results
  always @(posedge clk) begin : nl_model
    ekf_pkg::nl_res_t res;
    if (sys_rst) begin
      i_nl_done <= 1'b0;
      nl_wait  = 0;
      ref_pose = '0;
      for (int i = 0; i < ekf_pkg::LM_NUM; i++) begin
        ref_lm[i] = '0;
      end
    end else begin
      i_nl_done <= 1'b0;
      if (nl_wait > 0) begin
        nl_wait = nl_wait - 1;
        if (nl_wait == 0) begin
          for (int i = 0; i < ekf_pkg::NL_RESULTS; i++) begin
            res[i] = $random(nl_seed);
          end
          i_nl_res  <= res;
          i_nl_done <= 1'b1;
          exp_q.push_back(ref_step(cur_req, res));
        end
      end
      if (o_nl_init) begin
        init_count++;
        if (req_q.size() == 0) begin
          err_count++;
          $display("o_nl_init pulsed with no request outstanding");
        end else begin
          cur_req = req_q.pop_front();
          compare_op(o_nl_op, expect_op(cur_req));
          nl_wait = 1 + int'({$random(nl_seed)} % 6);
        end
      end
    end
  end

  // consumer returns one credit per record after a random delay
  always @(posedge clk) begin : consumer
    if (sys_rst) begin
      i_credit <= 1'b0;
      owed = 0;
    end else begin
      i_credit <= 1'b0;
      if (o_rec_val) begin
        owed = owed + 1;
      end
      if (owed > ekf_pkg::REC_CREDITS) begin
        err_count++;
        $display("more records sent than credits granted");
      end
      if (!hold_credits && owed > 0 && ({$random(cr_seed)} % 3) == 0) begin
        owed = owed - 1;
        i_credit <= 1'b1;
      end
    end
  end

  // record checker in exp_q order
  always @(posedge clk) begin : rec_check
    if (!sys_rst && o_rec_val) begin
      rec_count++;
      if (no_rec_window) begin
        err_count++;
        $display("a record was sent while the consumer held every credit");
      end
      if (exp_q.size() == 0) begin
        err_count++;
        $display("a record arrived with no step outstanding");
      end else begin
        compare_rec(o_rec, exp_q.pop_front());
      end
    end
  end

  initial begin : tests
    int start;
    int guard;
    guard = 0;
    do begin
      @(negedge clk);
      guard++;
      if (guard > WAIT_LIMIT) abort_run("reset was never released");
    end while (sys_rst);

    // idle outputs right after reset
    start = err_count;
    compare_flag("o_req_rdy", o_req_rdy, 1'b1);
    compare_flag("o_nl_init", o_nl_init, 1'b0);
    compare_flag("o_rec_val", o_rec_val, 1'b0);
    report_test("reset_idle", start);

    // pose accumulates into the next operands
    start = err_count;
    send_req(ekf_pkg::STEP_PREDICT, 3'd0);
    send_req(ekf_pkg::STEP_PREDICT, 3'd1);
    send_req(ekf_pkg::STEP_PREDICT, 3'd0);
    wait_drained("predict records did not arrive");
    report_test("predict", start);

    // slot 5 written twice while neighbours stay at zero
    start = err_count;
    send_req(ekf_pkg::STEP_NEWLM, 3'd5);
    send_req(ekf_pkg::STEP_NEWLM, 3'd5);
    send_req(ekf_pkg::STEP_UPDATE, 3'd5);
    send_req(ekf_pkg::STEP_UPDATE, 3'd4);
    send_req(ekf_pkg::STEP_UPDATE, 3'd6);
    wait_drained("new landmark records did not arrive");
    report_test("new_landmark", start);

    start = err_count;
    for (int i = 0; i < 6; i++) begin
      send_req(ekf_pkg::STEP_UPDATE, random_idx());
    end
    wait_drained("update records did not arrive");
    report_test("update", start);

    start = err_count;
    for (int i = 0; i < 16; i++) begin
      send_req(random_kind(), random_idx());
    end
    wait_drained("mixed records did not arrive");
    report_test("mixed", start);

    // spend every credit before filling the queue
    start = err_count;
    hold_credits = 1'b1;
    repeat (2) @(negedge clk);
    guard = 0;
    while (owed < ekf_pkg::REC_CREDITS) begin
      guard++;
      if (guard > ekf_pkg::REC_CREDITS + 1) abort_run("credits were not used up");
      send_req(random_kind(), random_idx());
      wait_drained("record with credit left did not arrive");
    end
    no_rec_window = 1'b1;
    for (int i = 0; i < ekf_pkg::QUEUE_DEPTH; i++) begin
      send_req(random_kind(), random_idx());
    end
    wait_queued(ekf_pkg::QUEUE_DEPTH);
    for (int c = 0; c < 8; c++) begin
      @(negedge clk);
      compare_flag("o_req_rdy", o_req_rdy, 1'b0);
    end
    no_rec_window = 1'b0;
    hold_credits  = 1'b0;
    wait_drained("held records did not arrive after credits returned");
    report_test("backpressure", start);

    finish_run();
  end

endmodule

`default_nettype wire

/* files.f */
design/ekf_pkg.sv
design/pose_map_store.sv
design/step_issue.sv
design/result_unpack.sv
design/record_queue.sv
design/ekf_step_top.sv
dv/tb_clk_gen.sv
dv/tb_ekf_step.sv
